// ==== Bender.yml ====
package:
  name: hb_shell

sources:
  - include_dirs:
      - .
    files:
      - hb_shell_pkg.sv
      - hb_config_rom.sv
      - hb_dff_chain.sv
      - hb_tag_bitbang.sv
      - hb_csr_ctrl.sv
      - hb_dram_addr_xlate.sv
      - hb_shell_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - hb_shell_chk.sv
      - tb_clk_gen.sv
      - tb_hb_shell.sv

// ==== filelist.f ====
+incdir+.
hb_shell_pkg.sv
hb_config_rom.sv
hb_dff_chain.sv
hb_tag_bitbang.sv
hb_csr_ctrl.sv
hb_dram_addr_xlate.sv
hb_shell_top.sv
hb_shell_chk.sv
tb_clk_gen.sv
tb_hb_shell.sv

// ==== hb_config_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hb_shell_config.svh"

module hb_config_rom
  (
    input  hb_shell_pkg::rom_addr_t addr_i,
    output hb_shell_pkg::csr_word_t data_o
  );

  import hb_shell_pkg::*;

  // machine parameters as seen by host software
  always_comb
  begin
    case (addr_i)
      rom_addr_t'(0): data_o = `HB_ROM_VERSION;
      rom_addr_t'(1): data_o = csr_word_t'(`HB_LG_NUM_DMA);
      rom_addr_t'(2): data_o = csr_word_t'(`HB_RESET_DEPTH);
      rom_addr_t'(3): data_o = csr_word_t'(`HB_CACHE_ADDR_W);
      rom_addr_t'(4): data_o = csr_word_t'(`HB_CSR_DATA_W);
      default:        data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hb_csr_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hb_shell_config.svh"

module hb_csr_ctrl
  (
    input  logic                        aclk_i,
    input  logic                        rst_i,

    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [`HB_WB_ADDR_W-1:0]    wb_adr_i,
    input  hb_shell_pkg::csr_word_t     wb_dat_i,
    output hb_shell_pkg::csr_word_t     wb_dat_o,
    output logic                        wb_ack_o,

    output logic                        tag_bit_v_o,
    output logic                        tag_bit_o,
    input  logic                        tag_ready_i,

    output logic                        sys_resetn_o,
    output hb_shell_pkg::dram_addr_t    dram_base_o,
    output hb_shell_pkg::rom_addr_t     rom_addr_o,
    input  hb_shell_pkg::csr_word_t     rom_data_i
  );

  import hb_shell_pkg::*;

  csr_word_t  reset_q;
  dram_addr_t base_q;
  rom_addr_t  rom_addr_q;
  csr_word_t  rdata_q;
  csr_word_t  rdata_d;
  logic       ack_q;
  logic       req;
  logic       tag_wr;
  logic       done;
  csr_idx_e   idx;

  //////////////////////////////////////////////////////////////////////
  // wishbone decode
  //////////////////////////////////////////////////////////////////////

  assign idx = csr_idx_e'(wb_adr_i);

  // stb is still up in the ack cycle, so that cycle is not a new access
  assign req    = wb_cyc_i & wb_stb_i & ~ack_q;
  assign tag_wr = req & wb_we_i & (idx == CSR_TAG);

  // tag writes wait here until the bitbang takes the bit
  assign done = req & (~tag_wr | tag_ready_i);

  assign tag_bit_v_o = tag_wr;
  assign tag_bit_o   = wb_dat_i[0];

  //////////////////////////////////////////////////////////////////////
  // register bank
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk_i)
  begin
    if (rst_i)
    begin
      ack_q      <= 1'b0;
      reset_q    <= '0;
      base_q     <= '0;
      rom_addr_q <= '0;
    end
    else
    begin
      ack_q <= done;
      if (done & wb_we_i)
      begin
        case (idx)
          CSR_RESET:     reset_q    <= wb_dat_i;
          CSR_DRAM_BASE: base_q     <= dram_addr_t'(wb_dat_i);
          CSR_ROM_ADDR:  rom_addr_q <= rom_addr_t'(wb_dat_i);
          // tag writes travel on the strobe and the rest are read only
          default:       ;
        endcase
      end
    end
  end

  // read mux with unmapped words reading as zero
  always_comb
  begin
    case (idx)
      CSR_RESET:     rdata_d = reset_q;
      CSR_TAG:       rdata_d = csr_word_t'(tag_ready_i);
      CSR_DRAM_BASE: rdata_d = csr_word_t'(base_q);
      CSR_ROM_ADDR:  rdata_d = csr_word_t'(rom_addr_q);
      CSR_ROM_DATA:  rdata_d = rom_data_i;
      default:       rdata_d = '0;
    endcase
  end

  always_ff @(posedge aclk_i)
  begin
    if (rst_i)
    begin
      rdata_q <= '0;
    end
    else if (done & ~wb_we_i)
    begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_ack_o     = ack_q;
  assign wb_dat_o     = rdata_q;
  assign sys_resetn_o = reset_q[0];
  assign dram_base_o  = base_q;
  assign rom_addr_o   = rom_addr_q;

endmodule

`default_nettype wire

// ==== hb_dff_chain.sv ====
`timescale 1ns/1ps
`default_nettype none

module hb_dff_chain
  #(
    parameter type   data_t      = logic,
    parameter int    depth_p     = 1,
    parameter data_t reset_val_p = '0
  )
  (
    input  logic  aclk_i,
    input  logic  rst_i,
    input  data_t data_i,
    output data_t data_o
  );

  data_t stage_q [depth_p];

  always_ff @(posedge aclk_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < depth_p; i++)
      begin
        stage_q[i] <= reset_val_p;
      end
    end
    else
    begin
      stage_q[0] <= data_i;
      for (int i = 1; i < depth_p; i++)
      begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[depth_p-1];

endmodule

`default_nettype wire

// ==== hb_dram_addr_xlate.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hb_shell_config.svh"

module hb_dram_addr_xlate
  (
    input  logic                         aclk_i,
    input  logic                         rst_i,

    input  logic                         dma_v_i,
    input  hb_shell_pkg::cache_id_t      dma_cache_id_i,
    input  logic [`HB_CACHE_ADDR_W-1:0]  dma_addr_i,
    input  hb_shell_pkg::dram_addr_t     dram_base_i,

    output logic                         dram_v_o,
    output hb_shell_pkg::dram_addr_t     dram_addr_o
  );

  import hb_shell_pkg::*;

  localparam int offset_w_lp = `HB_CACHE_ADDR_W - `HB_LG_NUM_DMA;

  dram_addr_t addr_hash;
  dram_req_t  req_li;
  dram_req_t  req_lo;

  // cache id on top of the per-cache offset, then relocated by the base
  assign addr_hash = dram_addr_t'({dma_cache_id_i, dma_addr_i[offset_w_lp-1:0]});

  assign req_li.v    = dma_v_i;
  assign req_li.addr = addr_hash + dram_base_i;

  hb_dff_chain
    #(
      .data_t      (dram_req_t),
      .depth_p     (`HB_ADDR_PIPE_DEPTH),
      .reset_val_p ('0)
    )
    addr_pipe
    (
      .aclk_i (aclk_i),
      .rst_i  (rst_i),
      .data_i (req_li),
      .data_o (req_lo)
    );

  assign dram_v_o    = req_lo.v;
  assign dram_addr_o = req_lo.addr;

endmodule

`default_nettype wire

// ==== hb_shell_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hb_shell_config.svh"

module hb_shell_chk
  (
    input logic                        aclk_i,
    input logic                        rst_i,
    input logic                        stb_i,
    input logic                        we_i,
    input logic [`HB_WB_ADDR_W-1:0]    adr_i,
    input logic                        ack_i,
    input logic                        tag_ready_i,
    input logic                        tag_clk_i,
    input logic                        tag_data_i,
    input logic                        resetn_i,
    input logic                        core_reset_i,
    input logic                        dma_v_i,
    input hb_shell_pkg::cache_id_t     dma_cache_id_i,
    input logic [`HB_CACHE_ADDR_W-1:0] dma_addr_i,
    input hb_shell_pkg::dram_addr_t    dram_base_i,
    input logic                        dram_v_i,
    input hb_shell_pkg::dram_addr_t    dram_addr_i
  );

  import hb_shell_pkg::*;

  localparam int offset_w_lp = `HB_CACHE_ADDR_W - `HB_LG_NUM_DMA;

  int         fail_count = 0;
  dram_addr_t exp_addr;

  function automatic void flag_failure(input string what);
    $error("%s", what);
    fail_count++;
  endfunction

  // cache id above the cache offset, then the programmed base on top
  assign exp_addr = (dram_addr_t'(dma_cache_id_i) << offset_w_lp)
                  + (dram_addr_t'(dma_addr_i) & ((dram_addr_t'(1) << offset_w_lp) - 1))
                  + dram_base_i;

  //////////////////////////////////////////////////////////////////////
  // wishbone handshake
  //////////////////////////////////////////////////////////////////////

  ack_pulse: assert property (@(posedge aclk_i) disable iff (rst_i) ack_i |=> !ack_i)
    else flag_failure("wishbone ack held longer than one cycle");

  ack_plain: assert property (@(posedge aclk_i) disable iff (rst_i)
    (stb_i && !ack_i && !(we_i && adr_i == CSR_TAG)) |=> ack_i)
    else flag_failure("wishbone ack missing one cycle after the strobe");

  // tag writes are acked only once the bitbang takes the bit
  ack_tag: assert property (@(posedge aclk_i) disable iff (rst_i)
    (stb_i && !ack_i && we_i && adr_i == CSR_TAG) |=> (ack_i == $past(tag_ready_i)))
    else flag_failure("tag write ack does not follow bitbang ready");

  //////////////////////////////////////////////////////////////////////
  // tag bitbang, reset chain, dram address path
  //////////////////////////////////////////////////////////////////////

  tag_clk_pulse: assert property (@(posedge aclk_i) disable iff (rst_i)
    tag_clk_i |=> !tag_clk_i)
    else flag_failure("tag clock high for more than one cycle");

  tag_data_held: assert property (@(posedge aclk_i) disable iff (rst_i)
    tag_clk_i |-> $stable(tag_data_i) ##1 $stable(tag_data_i))
    else flag_failure("tag data changed around the tag clock pulse");

  reset_delay: assert property (@(posedge aclk_i) disable iff (rst_i)
    core_reset_i == $past(!resetn_i, `HB_RESET_DEPTH))
    else flag_failure("core reset does not follow the reset register by the chain depth");

  dram_hit: assert property (@(posedge aclk_i) disable iff (rst_i)
    dma_v_i |-> ##`HB_ADDR_PIPE_DEPTH
      (dram_v_i && dram_addr_i == $past(exp_addr, `HB_ADDR_PIPE_DEPTH)))
    else flag_failure("dram request missing or wrong address after the pipeline delay");

  dram_idle: assert property (@(posedge aclk_i) disable iff (rst_i)
    !dma_v_i |-> ##`HB_ADDR_PIPE_DEPTH !dram_v_i)
    else flag_failure("dram valid raised with no request in flight");

endmodule

bind hb_shell_top hb_shell_chk chk
  (
    .aclk_i         (aclk_i),
    .rst_i          (rst_i),
    .stb_i          (wb_cyc_i & wb_stb_i),
    .we_i           (wb_we_i),
    .adr_i          (wb_adr_i),
    .ack_i          (wb_ack_o),
    .tag_ready_i    (tag_ready_lo),
    .tag_clk_i      (tag_clk_o),
    .tag_data_i     (tag_data_o),
    .resetn_i       (sys_resetn_lo),
    .core_reset_i   (core_reset_o),
    .dma_v_i        (dma_v_i),
    .dma_cache_id_i (dma_cache_id_i),
    .dma_addr_i     (dma_addr_i),
    .dram_base_i    (dram_base_lo),
    .dram_v_i       (dram_v_o),
    .dram_addr_i    (dram_addr_o)
  );

`default_nettype wire

// ==== hb_shell_config.svh ====
`ifndef HB_SHELL_CONFIG_SVH
`define HB_SHELL_CONFIG_SVH

// host register bus
`define HB_CSR_DATA_W       32
`define HB_WB_ADDR_W        3

// software reset
`define HB_RESET_DEPTH      3

// machine configuration rom of 16 words
`define HB_ROM_ADDR_W       4
`define HB_ROM_VERSION      32'h0001_0300

// cache dma side
`define HB_CACHE_ADDR_W     20
`define HB_LG_NUM_DMA       3

// dram side
`define HB_DRAM_ADDR_W      32
`define HB_ADDR_PIPE_DEPTH  2

`endif

// ==== hb_shell_pkg.sv ====
`default_nettype none

`include "hb_shell_config.svh"

package hb_shell_pkg;

  typedef logic [`HB_CSR_DATA_W-1:0] csr_word_t;

  // host register map in word addresses
  typedef enum logic [`HB_WB_ADDR_W-1:0]
  {
    CSR_RESET     = 0,
    CSR_TAG       = 1,
    CSR_DRAM_BASE = 2,
    CSR_ROM_ADDR  = 3,
    CSR_ROM_DATA  = 4
  } csr_idx_e;

  typedef logic [`HB_ROM_ADDR_W-1:0]  rom_addr_t;
  typedef logic [`HB_LG_NUM_DMA-1:0]  cache_id_t;
  typedef logic [`HB_DRAM_ADDR_W-1:0] dram_addr_t;

  // one translated request on its way to dram
  typedef struct packed
  {
    logic       v;
    dram_addr_t addr;
  } dram_req_t;

endpackage

`default_nettype wire

// ==== hb_shell_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hb_shell_config.svh"

module hb_shell_top
  (
    input  logic                         aclk_i,
    input  logic                         rst_i,

    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [`HB_WB_ADDR_W-1:0]     wb_adr_i,
    input  hb_shell_pkg::csr_word_t      wb_dat_i,
    output hb_shell_pkg::csr_word_t      wb_dat_o,
    output logic                         wb_ack_o,

    output logic                         tag_clk_o,
    output logic                         tag_data_o,
    output logic                         core_reset_o,

    input  logic                         dma_v_i,
    input  hb_shell_pkg::cache_id_t      dma_cache_id_i,
    input  logic [`HB_CACHE_ADDR_W-1:0]  dma_addr_i,
    output logic                         dram_v_o,
    output hb_shell_pkg::dram_addr_t     dram_addr_o
  );

  import hb_shell_pkg::*;

  logic       tag_bit_v_lo;
  logic       tag_bit_lo;
  logic       tag_ready_lo;
  logic       sys_resetn_lo;
  dram_addr_t dram_base_lo;
  rom_addr_t  rom_addr_lo;
  csr_word_t  rom_data_lo;

  hb_csr_ctrl csr
    (
      .aclk_i       (aclk_i),
      .rst_i        (rst_i),
      .wb_cyc_i     (wb_cyc_i),
      .wb_stb_i     (wb_stb_i),
      .wb_we_i      (wb_we_i),
      .wb_adr_i     (wb_adr_i),
      .wb_dat_i     (wb_dat_i),
      .wb_dat_o     (wb_dat_o),
      .wb_ack_o     (wb_ack_o),
      .tag_bit_v_o  (tag_bit_v_lo),
      .tag_bit_o    (tag_bit_lo),
      .tag_ready_i  (tag_ready_lo),
      .sys_resetn_o (sys_resetn_lo),
      .dram_base_o  (dram_base_lo),
      .rom_addr_o   (rom_addr_lo),
      .rom_data_i   (rom_data_lo)
    );

  hb_tag_bitbang bb
    (
      .aclk_i     (aclk_i),
      .rst_i      (rst_i),
      .bit_v_i    (tag_bit_v_lo),
      .bit_i      (tag_bit_lo),
      .ready_o    (tag_ready_lo),
      .tag_clk_o  (tag_clk_o),
      .tag_data_o (tag_data_o)
    );

  hb_config_rom configuration_rom
    (
      .addr_i (rom_addr_lo),
      .data_o (rom_data_lo)
    );

  // chain comes up asserted so the core waits for software to release it
  hb_dff_chain
    #(
      .data_t      (logic),
      .depth_p     (`HB_RESET_DEPTH),
      .reset_val_p (1'b1)
    )
    reset_dff
    (
      .aclk_i (aclk_i),
      .rst_i  (rst_i),
      .data_i (~sys_resetn_lo),
      .data_o (core_reset_o)
    );

  hb_dram_addr_xlate xlate
    (
      .aclk_i         (aclk_i),
      .rst_i          (rst_i),
      .dma_v_i        (dma_v_i),
      .dma_cache_id_i (dma_cache_id_i),
      .dma_addr_i     (dma_addr_i),
      .dram_base_i    (dram_base_lo),
      .dram_v_o       (dram_v_o),
      .dram_addr_o    (dram_addr_o)
    );

endmodule

`default_nettype wire

// ==== hb_tag_bitbang.sv ====
`timescale 1ns/1ps
`default_nettype none

module hb_tag_bitbang
  (
    input  logic aclk_i,
    input  logic rst_i,

    input  logic bit_v_i,
    input  logic bit_i,
    output logic ready_o,

    output logic tag_clk_o,
    output logic tag_data_o
  );

  typedef enum logic [1:0]
  {
    ST_IDLE   = 2'd0,
    ST_SETUP  = 2'd1,
    ST_CLK_HI = 2'd2
  } bb_state_e;

  bb_state_e state_q;
  logic      data_q;

  // data is set up one cycle before the clock pulse and held through it
  always_ff @(posedge aclk_i)
  begin
    if (rst_i)
    begin
      state_q <= ST_IDLE;
      data_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (bit_v_i)
          begin
            data_q  <= bit_i;
            state_q <= ST_SETUP;
          end
        end
        ST_SETUP:  state_q <= ST_CLK_HI;
        ST_CLK_HI: state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  assign ready_o    = (state_q == ST_IDLE);
  assign tag_clk_o  = (state_q == ST_CLK_HI);
  assign tag_data_o = data_q;

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
  #(
    parameter int period_p       = 8,
    parameter int reset_cycles_p = 4
  )
  (
    output logic clk_o,
    output logic rst_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

  // reset drops 1 ns after the last reset edge
  initial
  begin
    rst_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb_hb_shell.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hb_shell_config.svh"

module tb_hb_shell;

  import hb_shell_pkg::*;

  // cycles per test for reset, read-back, rom, reset chain, tag and dram burst
  localparam int budget_lp   = 5 + 20 + 30 + 25 + 40 + 20;
  localparam int timeout_lp  = 2 * budget_lp;
  localparam int tag_bits_lp = 8;
  localparam int burst_lp    = 8;

  logic                        aclk;
  logic                        rst;
  logic                        wb_cyc;
  logic                        wb_stb;
  logic                        wb_we;
  logic [`HB_WB_ADDR_W-1:0]    wb_adr;
  csr_word_t                   wb_wdat;
  csr_word_t                   wb_rdat;
  logic                        wb_ack;
  logic                        tag_clk;
  logic                        tag_data;
  logic                        core_reset;
  logic                        dma_v;
  cache_id_t                   dma_id;
  logic [`HB_CACHE_ADDR_W-1:0] dma_addr;
  logic                        dram_v;
  dram_addr_t                  dram_addr;

  logic [31:0] lcg_state = 32'hedc7ff15;
  int          cycles;
  int          errors;
  int          test_errors;
  int          tests_ok;
  int          tests_bad;
  int          lat;
  int          dram_count;
  csr_word_t   rd;
  csr_word_t   word;
  csr_word_t   rom_a;
  logic        tag_sent[$];
  logic        tag_seen[$];

  tb_clk_gen clk_gen
    (
      .clk_o (aclk),
      .rst_o (rst)
    );

  hb_shell_top DUT
    (
      .aclk_i         (aclk),
      .rst_i          (rst),
      .wb_cyc_i       (wb_cyc),
      .wb_stb_i       (wb_stb),
      .wb_we_i        (wb_we),
      .wb_adr_i       (wb_adr),
      .wb_dat_i       (wb_wdat),
      .wb_dat_o       (wb_rdat),
      .wb_ack_o       (wb_ack),
      .tag_clk_o      (tag_clk),
      .tag_data_o     (tag_data),
      .core_reset_o   (core_reset),
      .dma_v_i        (dma_v),
      .dma_cache_id_i (dma_id),
      .dma_addr_i     (dma_addr),
      .dram_v_o       (dram_v),
      .dram_addr_o    (dram_addr)
    );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // machine parameter table as host software expects it
  function automatic csr_word_t rom_expect(input int a);
    case (a)
      0:       return `HB_ROM_VERSION;
      1:       return `HB_LG_NUM_DMA;
      2:       return `HB_RESET_DEPTH;
      3:       return `HB_CACHE_ADDR_W;
      4:       return `HB_CSR_DATA_W;
      default: return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input csr_word_t exp, input csr_word_t act);
    assert (act === exp)
    else
    begin
      $display("Fail %0t ns %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    int total;
    total = errors + DUT.chk.fail_count;
    if (total == test_errors)
    begin
      tests_ok++;
      $display("test %s done, ok", name);
    end
    else
    begin
      tests_bad++;
      $display("test %s done, %0d errors", name, total - test_errors);
    end
    test_errors = total;
  endtask

  // one wishbone classic access entered 1 ns after an edge
  task automatic bus_access(input logic we, input logic [`HB_WB_ADDR_W-1:0] adr,
                            input csr_word_t wdat, output csr_word_t rdat, output int cnt);
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = adr;
    wb_wdat = wdat;
    cnt     = 0;
    do
    begin
      @(posedge aclk);
      #1;
      cnt++;
    end
    while (!wb_ack);
    rdat   = wb_rdat;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n)
    begin
      @(posedge aclk);
      #1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitors and timeout
  //////////////////////////////////////////////////////////////////////

  always @(posedge tag_clk)
  begin
    tag_seen.push_back(tag_data);
  end

  always @(negedge aclk)
  begin
    if (!rst && dram_v)
    begin
      dram_count++;
    end
  end

  always @(posedge aclk)
  begin
    cycles++;
    if (cycles > timeout_lp)
    begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_wdat     = '0;
    dma_v       = 1'b0;
    dma_id      = '0;
    dma_addr    = '0;
    cycles      = 0;
    errors      = 0;
    test_errors = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    dram_count  = 0;
    @(negedge rst);

    word  = lcg_next();
    rom_a = lcg_next() & 32'hf;
    bus_access(1'b1, CSR_DRAM_BASE, word, rd, lat);
    bus_access(1'b1, CSR_ROM_ADDR, rom_a, rd, lat);
    bus_access(1'b0, CSR_DRAM_BASE, '0, rd, lat);
    check_value("wb_dat_o", word, rd);
    bus_access(1'b0, CSR_ROM_ADDR, '0, rd, lat);
    check_value("wb_dat_o", rom_a, rd);
    for (int a = 5; a < 8; a++)
    begin
      bus_access(1'b0, a[`HB_WB_ADDR_W-1:0], '0, rd, lat);
      check_value("wb_dat_o", '0, rd);
    end
    finish_test("register read-back");

    for (int a = 0; a < 6; a++)
    begin
      bus_access(1'b1, CSR_ROM_ADDR, csr_word_t'(a), rd, lat);
      bus_access(1'b0, CSR_ROM_DATA, '0, rd, lat);
      check_value("wb_dat_o", rom_expect(a), rd);
    end
    finish_test("config rom");

    check_value("core_reset_o", 1, core_reset);
    bus_access(1'b1, CSR_RESET, 1, rd, lat);
    while (core_reset)
    begin
      wait_cycles(1);
    end
    bus_access(1'b0, CSR_RESET, '0, rd, lat);
    check_value("wb_dat_o", 1, rd);
    bus_access(1'b1, CSR_RESET, '0, rd, lat);
    while (!core_reset)
    begin
      wait_cycles(1);
    end
    finish_test("reset control");

    for (int i = 0; i < tag_bits_lp; i++)
    begin
      word = lcg_next();
      tag_sent.push_back(word[16]);
      bus_access(1'b1, CSR_TAG, csr_word_t'(word[16]), rd, lat);
      // a back-to-back access takes 2 cycles, the busy bitbang adds more
      if (i > 0)
      begin
        assert (lat > 2)
        else
        begin
          $display("tag write %0d was acked after %0d cycle while the bitbang was busy", i, lat);
          errors++;
        end
      end
    end
    while (tag_seen.size() < tag_bits_lp)
    begin
      wait_cycles(1);
    end
    for (int i = 0; i < tag_bits_lp; i++)
    begin
      check_value("tag_data_o", tag_sent[i], tag_seen[i]);
    end
    finish_test("tag bitbang");

    word = lcg_next();
    bus_access(1'b1, CSR_DRAM_BASE, word, rd, lat);
    dram_count = 0;
    for (int i = 0; i < burst_lp; i++)
    begin
      word     = lcg_next();
      dma_v    = 1'b1;
      dma_id   = word[31:32-`HB_LG_NUM_DMA];
      dma_addr = word[`HB_CACHE_ADDR_W-1:0];
      wait_cycles(1);
    end
    dma_v = 1'b0;
    wait_cycles(`HB_ADDR_PIPE_DEPTH + 2);
    check_value("dram_v_o count", burst_lp, dram_count);
    finish_test("dram address translation");

    wait_cycles(2);
    $display("tests ok %0d, failed %0d, errors %0d", tests_ok, tests_bad,
             errors + DUT.chk.fail_count);
    if (tests_bad == 0 && errors + DUT.chk.fail_count == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
